// File: include/miner_uart_macros.svh
`ifndef MINER_UART_MACROS_SVH
`define MINER_UART_MACROS_SVH

// ------------------------------------------------------------
// serial link constants
// ------------------------------------------------------------

// clock cycles per serial bit, small for quick simulation.
`define MINER_CLKS_PER_BIT 16

// bytes in one block header from the host.
`define MINER_HEADER_BYTES 80

// bytes in one nonce reply to the host.
`define MINER_NONCE_BYTES 4

`endif

// File: hw/miner_uart_pkg.sv
`default_nettype none

`include "miner_uart_macros.svh"

package miner_uart_pkg;

    // byte from the receiver, valid for one cycle per frame.
    typedef struct packed {
        logic       valid;
        logic       frame_error; // stop bit sampled low.
        logic [7:0] data;
    } rx_byte_t;

    // byte offered to the transmitter.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_byte_t;

    // first received byte ends up in the top 8 bits.
    typedef logic [`MINER_HEADER_BYTES*8-1:0] header_t;

    typedef logic [`MINER_NONCE_BYTES*8-1:0] nonce_t;

    typedef struct packed {
        logic        header_ready;
        logic [31:0] byte_count; // running count, wraps.
    } link_status_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_uart_macros.svh"

module uart_rx (
    input  wire                           clock,
    input  wire                           rst,
    input  wire                           rxd,
    output miner_uart_pkg::rx_byte_t      rx_byte
);

    localparam int CLKS  = `MINER_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             valid_q;
    logic             error_q;
    logic             bit_done;

    assign bit_done = (clk_cnt == CNT_W'(CLKS - 1)); // one full bit period elapsed.

    // ------------------------------------------------------------
    // two-flop synchronizer, line idles high
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    // ------------------------------------------------------------
    // frame FSM, samples at bit midpoints
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= rx_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
            error_q <= 1'b0;
        end else begin
            valid_q <= 1'b0; // single cycle strobe.
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= rx_start; // falling start edge.
                    end
                end
                rx_start: begin
                    if (clk_cnt == CNT_W'(CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? rx_idle : rx_data; // drop glitches.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_done) begin
                        valid_q <= 1'b1;
                        error_q <= ~rxd_sync; // stop bit must be high.
                        state   <= rx_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits arrive lsb first.
    always_ff @(posedge clock) begin
        if (state == rx_data && bit_done) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

    assign rx_byte = '{valid: valid_q, frame_error: error_q, data: shift_q};

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_uart_macros.svh"

module uart_tx (
    input  wire                           clock,
    input  wire                           rst,
    input  wire miner_uart_pkg::tx_byte_t tx_byte,
    output logic                          busy,
    output logic                          txd
);

    localparam int CLKS  = `MINER_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bits_left; // bits still to go after the current one.
    logic [8:0]       shift_q;   // data bits then stop bit.
    logic             accept;
    logic             bit_done;

    assign accept   = tx_byte.valid & ~busy;
    assign bit_done = busy && (clk_cnt == CNT_W'(CLKS - 1));

    // ------------------------------------------------------------
    // frame control
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            busy      <= 1'b0;
            txd       <= 1'b1;
            clk_cnt   <= '0;
            bits_left <= '0;
        end else if (!busy) begin
            clk_cnt <= '0;
            if (tx_byte.valid) begin
                busy      <= 1'b1;
                txd       <= 1'b0; // start bit.
                bits_left <= 4'd9;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            if (bits_left == 4'd0) begin
                busy <= 1'b0; // stop bit finished.
            end else begin
                txd       <= shift_q[0];
                bits_left <= bits_left - 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // shift register refills with ones so the line ends idle.
    always_ff @(posedge clock) begin
        if (accept) begin
            shift_q <= {1'b1, tx_byte.data};
        end else if (bit_done && bits_left != 4'd0) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/header_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_uart_macros.svh"

module header_collector (
    input  wire                           clock,
    input  wire                           rst,
    input  wire miner_uart_pkg::rx_byte_t rx_byte,
    output miner_uart_pkg::header_t       header,
    output miner_uart_pkg::link_status_t  status
);

    localparam int HDR_BYTES = `MINER_HEADER_BYTES;
    localparam int IDX_W     = $clog2(HDR_BYTES);

    logic             accept;
    logic [IDX_W-1:0] hdr_idx; // position within the current header.
    logic             ready_q;
    logic [31:0]      count_q;

    assign accept = rx_byte.valid & ~rx_byte.frame_error; // bad frames are dropped.

    // ------------------------------------------------------------
    // byte counters and ready flag
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            hdr_idx <= '0;
            ready_q <= 1'b0;
            count_q <= '0;
        end else if (accept) begin
            count_q <= count_q + 32'd1;
            if (hdr_idx == IDX_W'(HDR_BYTES - 1)) begin
                hdr_idx <= '0;
                ready_q <= 1'b1; // last byte of the header.
            end else begin
                hdr_idx <= hdr_idx + 1'b1;
                ready_q <= 1'b0; // a new header has begun.
            end
        end
    end

    // newest byte enters at the bottom.
    always_ff @(posedge clock) begin
        if (accept) begin
            header <= {header[$bits(header)-9:0], rx_byte.data};
        end
    end

    assign status = '{header_ready: ready_q, byte_count: count_q};

endmodule

`default_nettype wire

// File: hw/nonce_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_uart_macros.svh"

module nonce_sender (
    input  wire                           clock,
    input  wire                           rst,
    input  wire                           transmit_data,
    input  wire miner_uart_pkg::nonce_t   nonce,
    input  wire                           busy,
    output miner_uart_pkg::tx_byte_t      tx_byte
);

    import miner_uart_pkg::*;

    localparam int NONCE_BYTES = `MINER_NONCE_BYTES;
    localparam int REM_W       = $clog2(NONCE_BYTES + 1);

    nonce_t           nonce_q;   // top byte is the one on offer.
    logic             req_prev;
    logic             req_rise;
    logic             busy_prev;
    logic             busy_fall;
    logic             valid_q;
    logic [REM_W-1:0] remaining; // frames not yet finished.
    logic             start;

    assign busy_fall = busy_prev & ~busy;
    assign start     = req_rise && (remaining == '0); // ignore requests mid reply.

    // ------------------------------------------------------------
    // request edge and reply sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            req_prev  <= 1'b0;
            req_rise  <= 1'b0;
            busy_prev <= 1'b0;
            valid_q   <= 1'b0;
            remaining <= '0;
        end else begin
            req_prev  <= transmit_data;
            req_rise  <= transmit_data & ~req_prev;
            busy_prev <= busy;
            valid_q   <= 1'b0;
            if (start) begin
                remaining <= REM_W'(NONCE_BYTES);
                valid_q   <= 1'b1; // first byte.
            end else if (remaining != '0 && busy_fall) begin
                remaining <= remaining - 1'b1;
                if (remaining != REM_W'(1)) begin
                    valid_q <= 1'b1; // next byte once the line is free.
                end
            end
        end
    end

    // capture then step through bytes msb first.
    always_ff @(posedge clock) begin
        if (start) begin
            nonce_q <= nonce;
        end else if (busy_fall && remaining > REM_W'(1)) begin
            nonce_q <= nonce_q << 8;
        end
    end

    assign tx_byte = '{valid: valid_q, data: nonce_q[$bits(nonce_t)-1 -: 8]};

endmodule

`default_nettype wire

// File: hw/miner_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module miner_uart_core (
    input  wire                         clock,
    input  wire                         rst,
    input  wire                         rxd,
    output logic                        txd,
    input  wire miner_uart_pkg::nonce_t nonce_input,
    input  wire                         transmit_data,
    output miner_uart_pkg::header_t     header_data,
    output logic                        header_ready,
    output logic [31:0]                 byte_count
);

    import miner_uart_pkg::*;

    rx_byte_t     rx_byte;
    tx_byte_t     tx_byte;
    link_status_t status;
    logic         tx_busy;

    // ------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------
    uart_rx u_rx (
        .clock   (clock),
        .rst     (rst),
        .rxd     (rxd),
        .rx_byte (rx_byte)
    );

    header_collector u_collector (
        .clock   (clock),
        .rst     (rst),
        .rx_byte (rx_byte),
        .header  (header_data),
        .status  (status)
    );

    assign header_ready = status.header_ready;
    assign byte_count   = status.byte_count;

    // ------------------------------------------------------------
    // transmit path
    // ------------------------------------------------------------
    nonce_sender u_sender (
        .clock         (clock),
        .rst           (rst),
        .transmit_data (transmit_data),
        .nonce         (nonce_input),
        .busy          (tx_busy),
        .tx_byte       (tx_byte)
    );

    uart_tx u_tx (
        .clock   (clock),
        .rst     (rst),
        .tx_byte (tx_byte),
        .busy    (tx_busy), // only back-pressure toward the sender.
        .txd     (txd)
    );

endmodule

`default_nettype wire

// File: testbench/tb_miner_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "miner_uart_macros.svh"

module tb_miner_uart_core;

    import miner_uart_pkg::*;

    localparam int CLKS      = `MINER_CLKS_PER_BIT;
    localparam int HDR_BYTES = `MINER_HEADER_BYTES;
    // about 170 frames of 176 cycles plus idle checks and margin.
    localparam int CYCLE_LIMIT = 40000;

    logic        clock;
    logic        rst;
    logic        rxd;
    logic        txd;
    nonce_t      nonce_input;
    logic        transmit_data;
    header_t     header_data;
    logic        header_ready;
    logic [31:0] byte_count;

    integer      seed = 32'h6b39;
    int          errors = 0;
    int          cycle_count = 0;
    header_t     exp_header;
    logic [7:0]  value;
    logic [7:0]  good_byte;

    miner_uart_core UUT (
        .clock         (clock),
        .rst           (rst),
        .rxd           (rxd),
        .txd           (txd),
        .nonce_input   (nonce_input),
        .transmit_data (transmit_data),
        .header_data   (header_data),
        .header_ready  (header_ready),
        .byte_count    (byte_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // check and line helpers
    // ------------------------------------------------------------
    task automatic check_equal(input string name, input header_t expected, input header_t actual);
        assert (expected === actual) else begin
            errors++;
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // one 8N1 frame on rxd, then one idle bit period.
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            #1 rxd = frame[i];
            repeat (CLKS - 1) @(posedge clock);
        end
        @(posedge clock);
        #1 rxd = 1'b1;
        repeat (CLKS - 1) @(posedge clock); // lets a bad frame's false start die out.
    endtask

    // samples txd on falling edges, at bit midpoints.
    task automatic capture_byte(output logic [7:0] data, output logic stop_bit);
        while (txd !== 1'b0) @(negedge clock);
        repeat (CLKS / 2) @(negedge clock);
        assert (txd === 1'b0) else begin
            errors++;
            $display("start bit on txd ended before its midpoint");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clock);
            data[i] = txd; // lsb first.
        end
        repeat (CLKS) @(negedge clock);
        stop_bit = txd;
    endtask

    task automatic check_idle(input int cycles, input string name);
        logic seen_start;
        seen_start = 1'b0;
        repeat (cycles) begin
            @(negedge clock);
            if (txd !== 1'b1) seen_start = 1'b1;
        end
        assert (!seen_start) else begin
            errors++;
            $display("%s: unexpected start bit on txd", name);
        end
    endtask

    // drops then raises the request and expects the nonce msb first.
    task automatic nonce_reply(input string name);
        nonce_t     nonce;
        logic [7:0] data;
        logic       stop_bit;
        nonce = $random(seed);
        @(posedge clock);
        #1 transmit_data = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        nonce_input   = nonce;
        transmit_data = 1'b1;
        for (int i = 3; i >= 0; i--) begin
            capture_byte(data, stop_bit);
            check_equal($sformatf("%s byte %0d", name, i), header_t'(nonce[8*i +: 8]),
                        header_t'(data));
            assert (stop_bit === 1'b1) else begin
                errors++;
                $display("%s: stop bit of byte %0d was low", name, i);
            end
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        rst           = 1'b1;
        rxd           = 1'b1;
        nonce_input   = '0;
        transmit_data = 1'b0;
        repeat (10) @(posedge clock);
        #1 rst = 1'b0;
        @(posedge clock);
        #1;
        check_equal("reset txd", 1'b1, txd);
        check_equal("reset header_ready", 1'b0, header_ready);
        check_equal("reset byte_count", 0, byte_count);

        exp_header = '0;
        for (int i = 0; i < HDR_BYTES; i++) begin
            value = $random(seed);
            exp_header[$bits(header_t)-1-8*i -: 8] = value; // first byte at the top.
            send_byte(value, 1'b0);
        end
        check_equal("header ready", 1'b1, header_ready);
        check_equal("header data", exp_header, header_data);
        check_equal("header byte_count", 80, byte_count);

        send_byte($random(seed), 1'b1);
        check_equal("bad stop byte_count", 80, byte_count);
        check_equal("bad stop header data", exp_header, header_data);
        check_equal("bad stop header_ready", 1'b1, header_ready);
        good_byte = $random(seed);
        send_byte(good_byte, 1'b0);
        check_equal("new header header_ready", 1'b0, header_ready);
        check_equal("new header byte_count", 81, byte_count);
        check_equal("new header low byte", good_byte, header_data[7:0]);
        check_equal("new header shift", {exp_header[$bits(header_t)-9:0], good_byte},
                    header_data);

        nonce_reply("nonce");
        check_idle(400, "held request");
        nonce_reply("second nonce");

        // the good byte above already opened this header.
        exp_header = '0;
        exp_header[$bits(header_t)-1 -: 8] = good_byte;
        fork
            begin
                for (int i = 1; i < HDR_BYTES; i++) begin
                    value = $random(seed);
                    exp_header[$bits(header_t)-1-8*i -: 8] = value;
                    send_byte(value, 1'b0);
                end
            end
            begin
                repeat (300) @(posedge clock);
                nonce_reply("overlap nonce");
            end
        join
        check_equal("overlap header ready", 1'b1, header_ready);
        check_equal("overlap header data", exp_header, header_data);
        check_equal("overlap byte_count", 160, byte_count);
        check_idle(200, "after overlap reply");

        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/miner_uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/header_collector.sv
hw/nonce_sender.sv
hw/miner_uart_core.sv
testbench/tb_miner_uart_core.sv
